//--- Makefile
TOOL     := verilator
TOP      := tb_tlp_tx_read_ctrl
FILELIST := list.f
BUILD    := obj_dir
FLAGS    := --binary --timing -j 0 --top-module $(TOP) --Mdir $(BUILD)
LOG      := sim.log
PASS_MSG := Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL) and run the testbench, result in $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- dv/tb_tasks.svh
task automatic check_value(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
  if (actual !== expected)
  begin
    $display("[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
    stop_on_failure();
  end
endtask

// max read request size field decode
function automatic int max_rd_bytes(input logic [2:0] code);
  if (code == 3'd0)
    return 128;
  if (code == 3'd1)
    return 256;
  return 512;
endfunction

task automatic idle_gap();
  repeat ($urandom_range(5, 1)) @(negedge AvlClk_i);
endtask

task automatic set_max_rd_code(input logic [2:0] code);
  DevCsr_i = '0;
  DevCsr_i[avl_cfg_pkg::MaxRdSizeLsb +: 3] = code;
endtask

task automatic drive_read(input logic [31:0] addr,
                          input logic [avl_cfg_pkg::BurstWidth-1:0] burst);
  TxChipSelect_i = 1'b1;
  TxRead_i       = 1'b1;
  TxAddress_i    = addr;
  TxBurstCount_i = burst;
endtask

// holds the request until waitrequest drops and releases it afterwards
task automatic wait_accept();
  int waited;
  waited = 0;
  @(posedge AvlClk_i);
  while (TxWaitRequest_o)
  begin
    waited++;
    if (waited > AcceptLimit)
    begin
      $display("read at 0x%0h was never accepted", TxAddress_i);
      stop_on_failure();
    end
    @(posedge AvlClk_i);
  end
  @(negedge AvlClk_i);
  TxChipSelect_i = 1'b0;
  TxRead_i       = 1'b0;
endtask

task automatic issue_read(input logic [31:0] addr,
                          input logic [avl_cfg_pkg::BurstWidth-1:0] burst);
  drive_read(addr, burst);
  wait_accept();
endtask

task automatic return_data(input int words);
  repeat (words)
  begin
    @(negedge AvlClk_i);
    TxsReadDataValid_i = 1'b1;
    @(negedge AvlClk_i);
    TxsReadDataValid_i = 1'b0;
  end
endtask

task automatic wait_headers(input int count);
  int waited;
  waited = 0;
  while (hdr_q.size() < count)
  begin
    @(negedge AvlClk_i);
    waited++;
    if (waited > HdrWaitLimit)
    begin
      $display("only %0d of %0d headers written in time", hdr_q.size(), count);
      stop_on_failure();
    end
  end
endtask

task automatic check_hdr(input logic [tlp_hdr_pkg::HdrWidth-1:0] hdr,
                         input logic [63:0] addr, input logic [3:0] flags, input int len,
                         input int tag, input logic msi, input logic [3:0] lbe,
                         input logic last);
  check_value("TxReqHeader_o.addr", hdr[tlp_hdr_pkg::AddrLsb +: 64], addr);
  check_value("TxReqHeader_o.type", 64'(hdr[tlp_hdr_pkg::IsRd32Bit +: 4]), 64'(flags));
  check_value("TxReqHeader_o.fbe", 64'(hdr[tlp_hdr_pkg::FbeLsb +: 4]), 64'hf);
  check_value("TxReqHeader_o.tag", 64'(hdr[tlp_hdr_pkg::TagLsb +: 4]), 64'(tag));
  check_value("TxReqHeader_o.msi", 64'(hdr[tlp_hdr_pkg::MsiBit]), 64'(msi));
  check_value("TxReqHeader_o.len", 64'(hdr[tlp_hdr_pkg::LenLsb +: 9]), 64'(len));
  check_value("TxReqHeader_o.lbe", 64'(hdr[tlp_hdr_pkg::LbeLsb +: 4]), 64'(lbe));
  check_value("TxReqHeader_o.last", 64'(hdr[tlp_hdr_pkg::LastSubRdBit]), 64'(last));
endtask

// expected segments are limited by the rest of the burst, the 4 KB boundary and the max size
task automatic check_read_hdrs(input logic [31:0] addr,
                               input logic [avl_cfg_pkg::BurstWidth-1:0] burst,
                               input logic [2:0] code, input int count);
  logic [tlp_hdr_pkg::HdrWidth-1:0] hdr;
  logic [31:0]                      seg_addr;
  int                               remain;
  int                               to_bnd;
  int                               seg;
  remain   = int'(burst) * avl_cfg_pkg::WordBytes;
  seg_addr = {addr[31:4], 4'h0};
  wait_headers(count);
  for (int i = 0; i < count; i++)
  begin
    to_bnd = tlp_hdr_pkg::BoundaryBytes - int'(seg_addr[11:0]);
    seg    = remain;
    if (to_bnd < seg)
      seg = to_bnd;
    if (max_rd_bytes(code) < seg)
      seg = max_rd_bytes(code);
    hdr = hdr_q.pop_front();
    // upper address half is always zero here so rd32 is set
    check_hdr(hdr, 64'(seg_addr), 4'b0001, seg / tlp_hdr_pkg::DwBytes, exp_tag, 1'b0,
              4'hf, seg == remain);
    exp_tag  = (exp_tag + 1) % 16;
    seg_addr = seg_addr + 32'(seg);
    remain   = remain - seg;
  end
endtask

task automatic test_single_read();
  set_max_rd_code(3'd0);
  issue_read(32'h0000_0100, 6'd2);
  check_read_hdrs(32'h0000_0100, 6'd2, 3'd0, 1);
  return_data(2);
  idle_gap();
endtask

task automatic test_split_max_size();
  set_max_rd_code(3'd0);
  issue_read(32'h0000_2000, 6'd40);
  check_read_hdrs(32'h0000_2000, 6'd40, 3'd0, 5);  // five 128 byte pieces
  return_data(40);
  idle_gap();
endtask

task automatic test_split_boundary();
  set_max_rd_code(3'd2);
  issue_read(32'h0000_0fc0, 6'd8);
  check_read_hdrs(32'h0000_0fc0, 6'd8, 3'd2, 2);
  return_data(8);
  idle_gap();
endtask

task automatic test_pending_limit();
  logic [avl_cfg_pkg::BurstWidth-1:0] burst;
  set_max_rd_code(3'd0);
  for (int i = 0; i < 8; i++)
  begin
    burst = (i == 0) ? 6'd3 : 6'd2;
    issue_read(32'h4000 + 32'(i) * 32'h100, burst);
    check_read_hdrs(32'h4000 + 32'(i) * 32'h100, burst, 3'd0, 1);
  end
  drive_read(32'h0000_5000, 6'd4);  // ninth read with all slots taken
  repeat (16)
  begin
    @(posedge AvlClk_i);
    check_value("TxWaitRequest_o", 64'(TxWaitRequest_o), 64'd1);
  end
  @(negedge AvlClk_i);
  return_data(3);  // completes the oldest read only
  wait_accept();
  check_read_hdrs(32'h0000_5000, 6'd4, 3'd0, 1);
  return_data(7 * 2 + 4);
  idle_gap();
endtask

task automatic test_msi_events();
  logic [tlp_hdr_pkg::HdrWidth-1:0] hdr;
  MsiCsr_i     = 16'h0001;
  MsiAddr_i    = 64'h0000_0000_fee0_1000;
  PCIeIrqEna_i = 32'h0000_0001;
  RxmIrq_i     = 1'b1;
  wait_headers(1);
  hdr = hdr_q.pop_front();
  check_hdr(hdr, 64'h0000_0000_fee0_1000, 4'b0100, 1, 0, 1'b1, 4'h0, 1'b0);  // wr32
  RxmIrq_i = 1'b0;
  idle_gap();

  MsiAddr_i     = 64'h0000_0001_0000_0040;
  PCIeIrqEna_i  = 32'h0020_0000;  // mailbox 5 enable
  A2PMbWrAddr_i = 3'd5;
  A2PMbWrReq_i  = 1'b1;
  @(negedge AvlClk_i);
  A2PMbWrReq_i = 1'b0;
  wait_headers(1);
  hdr = hdr_q.pop_front();
  check_hdr(hdr, 64'h0000_0001_0000_0040, 4'b1000, 1, 0, 1'b1, 4'h0, 1'b0);  // wr64
  idle_gap();

  // same events give nothing with msi disabled
  MsiCsr_i     = 16'h0000;
  PCIeIrqEna_i = 32'h0020_0001;
  RxmIrq_i     = 1'b1;
  A2PMbWrReq_i = 1'b1;
  @(negedge AvlClk_i);
  A2PMbWrReq_i = 1'b0;
  repeat (30) @(negedge AvlClk_i);
  check_value("headers with MSI disabled", 64'(hdr_q.size()), 64'd0);
  check_value("CmdFifoBusy_o", 64'(CmdFifoBusy_o), 64'd0);
  RxmIrq_i = 1'b0;
  idle_gap();
endtask

task automatic test_backpressure();
  set_max_rd_code(3'd1);
  CmdFifoUsedW_i = 4'd9;  // one above the ok level
  issue_read(32'h0000_0340, 6'd2);
  repeat (20)
  begin
    @(negedge AvlClk_i);
    check_value("headers while FIFO full", 64'(hdr_q.size()), 64'd0);
    check_value("CmdFifoBusy_o", 64'(CmdFifoBusy_o), 64'd1);
  end
  CmdFifoUsedW_i = 4'd3;
  check_read_hdrs(32'h0000_0340, 6'd2, 3'd1, 1);
  return_data(2);
  idle_gap();
endtask

//--- dv/tb_tlp_tx_read_ctrl.sv
`timescale 1ns/100ps

module tb_tlp_tx_read_ctrl;

  localparam int AddrWidth     = 32;
  localparam int ResetCycles   = 10;
  localparam int AcceptLimit   = 100;    // cycles a read may wait for acceptance
  localparam int HdrWaitLimit  = 200;    // cycles to wait for the expected headers
  // limit on the whole run far above the length of the test sequence
  localparam int TimeoutCycles = 20000;

  logic                                     AvlClk_i;
  logic                                     Rstn_i;
  logic                                     TxChipSelect_i;
  logic                                     TxRead_i;
  logic [avl_cfg_pkg::BurstWidth-1:0]       TxBurstCount_i;
  logic [AddrWidth-1:0]                     TxAddress_i;
  logic                                     TxWaitRequest_o;
  logic [avl_cfg_pkg::CmdFifoUsedWidth-1:0] CmdFifoUsedW_i;
  logic                                     TxReqWr_o;
  logic [tlp_hdr_pkg::HdrWidth-1:0]         TxReqHeader_o;
  logic                                     CmdFifoBusy_o;
  logic                                     TxsReadDataValid_i;
  logic [31:0]                              DevCsr_i;
  logic                                     MasterEnable_i;
  logic [15:0]                              MsiCsr_i;
  logic [tlp_hdr_pkg::PcieAddrWidth-1:0]    MsiAddr_i;
  logic [avl_cfg_pkg::IrqEnaWidth-1:0]      PCIeIrqEna_i;
  logic [0:0]                               RxmIrq_i;
  logic                                     A2PMbWrReq_i;
  logic [avl_cfg_pkg::MbAddrBits-1:0]       A2PMbWrAddr_i;

  logic [tlp_hdr_pkg::HdrWidth-1:0] hdr_q [$];  // headers seen on the command fifo port
  int                               exp_tag;    // tag of the next read header
  int unsigned                      cycle_cnt = 0;

  tlp_tx_read_ctrl #(
    .AddrWidth       (AddrWidth),
    .IrqNum          (1),
    .MaxPendingReads (8),
    .FifoDepth       (16)
  ) tlp_tx_read_ctrl_i (
    .AvlClk_i           (AvlClk_i),
    .Rstn_i             (Rstn_i),
    .TxChipSelect_i     (TxChipSelect_i),
    .TxRead_i           (TxRead_i),
    .TxBurstCount_i     (TxBurstCount_i),
    .TxAddress_i        (TxAddress_i),
    .TxWaitRequest_o    (TxWaitRequest_o),
    .CmdFifoUsedW_i     (CmdFifoUsedW_i),
    .TxReqWr_o          (TxReqWr_o),
    .TxReqHeader_o      (TxReqHeader_o),
    .CmdFifoBusy_o      (CmdFifoBusy_o),
    .TxsReadDataValid_i (TxsReadDataValid_i),
    .DevCsr_i           (DevCsr_i),
    .MasterEnable_i     (MasterEnable_i),
    .MsiCsr_i           (MsiCsr_i),
    .MsiAddr_i          (MsiAddr_i),
    .PCIeIrqEna_i       (PCIeIrqEna_i),
    .RxmIrq_i           (RxmIrq_i),
    .A2PMbWrReq_i       (A2PMbWrReq_i),
    .A2PMbWrAddr_i      (A2PMbWrAddr_i)
  );

  initial
  begin
    AvlClk_i = 1'b0;
    forever #4 AvlClk_i = ~AvlClk_i;  // 125 MHz
  end

  task automatic stop_on_failure();
    $display("Testbench failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  // header monitor
  always @(posedge AvlClk_i)
  begin
    if (TxReqWr_o)
      hdr_q.push_back(TxReqHeader_o);
  end

  always @(posedge AvlClk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles)
    begin
      $display("run did not finish within %0d cycles", TimeoutCycles);
      stop_on_failure();
    end
  end

  `include "tb_tasks.svh"

  initial
  begin
    void'($urandom(32'h1af8_c94c));
    Rstn_i             = 1'b0;
    TxChipSelect_i     = 1'b0;
    TxRead_i           = 1'b0;
    TxBurstCount_i     = '0;
    TxAddress_i        = '0;
    CmdFifoUsedW_i     = '0;
    TxsReadDataValid_i = 1'b0;
    DevCsr_i           = '0;
    MasterEnable_i     = 1'b1;
    MsiCsr_i           = '0;
    MsiAddr_i          = '0;
    PCIeIrqEna_i       = '0;
    RxmIrq_i           = '0;
    A2PMbWrReq_i       = 1'b0;
    A2PMbWrAddr_i      = '0;
    exp_tag            = 0;

    repeat (ResetCycles) @(negedge AvlClk_i);
    check_value("TxReqWr_o", 64'(TxReqWr_o), 64'd0);
    check_value("TxWaitRequest_o", 64'(TxWaitRequest_o), 64'd1);
    check_value("CmdFifoBusy_o", 64'(CmdFifoBusy_o), 64'd0);
    Rstn_i = 1'b1;
    idle_gap();

    test_single_read();
    test_split_max_size();
    test_split_boundary();
    test_pending_limit();
    test_msi_events();
    test_backpressure();

    $display("Testbench passed");
    $finish;
  end

endmodule

//--- list.f
+incdir+dv
logic/avl_cfg_pkg.sv
logic/tlp_hdr_pkg.sv
logic/rd_split_calc.sv
logic/pending_rd_tracker.sv
logic/msi_request.sv
logic/txs_req_ctrl.sv
logic/tlp_tx_read_ctrl.sv
dv/tb_tlp_tx_read_ctrl.sv

//--- logic/avl_cfg_pkg.sv
package avl_cfg_pkg;

  // avalon slave side
  parameter int BurstWidth = 6;         // up to 63 words in a burst
  parameter int WordBytes  = 16;        // one 128-bit avalon word

  // command fifo fill level
  parameter int CmdFifoUsedWidth = 4;
  parameter int CmdFifoOkMax     = 8;   // header may be written at or below this level

  // max read request size field in the device control register
  parameter int MaxRdSizeLsb   = 12;
  parameter int MaxRdSizeWidth = 3;
  parameter int RdSize128      = 128;   // code 0
  parameter int RdSize256      = 256;   // code 1
  parameter int RdSize512      = 512;   // all other codes

  // byte count of one read sized for a full burst of words
  parameter int RdBytesWidth = 10;

  // interrupt enable register
  parameter int IrqEnaWidth = 32;
  parameter int MbIrqEnaLsb = 16;       // eight mailbox enables from here upward
  parameter int MbAddrBits  = 3;

endpackage

//--- logic/msi_request.sv
`timescale 1ns/100ps

module msi_request #(
  parameter int IrqNum = 1
) (
  input  logic                                 AvlClk_i,
  input  logic                                 Rstn_i,
  input  logic [IrqNum-1:0]                    RxmIrq_i,
  input  logic [avl_cfg_pkg::IrqEnaWidth-1:0]  PCIeIrqEna_i,
  input  logic                                 A2PMbWrReq_i,
  input  logic [avl_cfg_pkg::MbAddrBits-1:0]   A2PMbWrAddr_i,
  input  logic                                 msi_en_i,
  input  logic                                 msi_sent_i,
  output logic                                 msi_pending_o
);

  localparam int MbNum = 2 ** avl_cfg_pkg::MbAddrBits;

  logic             irq_any;
  logic             irq_q;
  logic             irq_rise;
  logic [MbNum-1:0] mb_ena;
  logic             mb_hit;
  logic             msi_set;

  assign irq_any = |(RxmIrq_i & PCIeIrqEna_i[IrqNum-1:0]);

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      irq_q <= 1'b0;
    else
      irq_q <= irq_any;
  end

  assign irq_rise = irq_any & ~irq_q;

  // mailbox write raises an msi only if its slot is enabled
  assign mb_ena  = PCIeIrqEna_i[avl_cfg_pkg::MbIrqEnaLsb +: MbNum];
  assign mb_hit  = A2PMbWrReq_i & mb_ena[A2PMbWrAddr_i];
  assign msi_set = (irq_rise | mb_hit) & msi_en_i;

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      msi_pending_o <= 1'b0;
    else if (msi_set)
      msi_pending_o <= 1'b1;  // a new event is never dropped
    else if (msi_sent_i)
      msi_pending_o <= 1'b0;
  end

endmodule

//--- logic/pending_rd_tracker.sv
`timescale 1ns/100ps

module pending_rd_tracker #(
  parameter int MaxPendingReads = 8,
  parameter int FifoDepth       = 16
) (
  input  logic                                AvlClk_i,
  input  logic                                Rstn_i,
  input  logic                                rd_accept_i,
  input  logic [avl_cfg_pkg::BurstWidth-1:0]  burst_count_i,
  input  logic                                TxsReadDataValid_i,
  output logic                                rd_slot_free_o
);

  localparam int BurstWidth = avl_cfg_pkg::BurstWidth;
  localparam int PtrWidth   = $clog2(FifoDepth);
  localparam int CntWidth   = $clog2(MaxPendingReads + 1);

  logic [BurstWidth-1:0] fifo_mem [FifoDepth];
  logic [PtrWidth-1:0]   wr_ptr;
  logic [PtrWidth-1:0]   rd_ptr;
  logic [CntWidth-1:0]   out_cnt;     // reads accepted and not fully returned
  logic [BurstWidth-1:0] valid_cnt;   // data words returned for the oldest read
  logic                  fifo_empty;
  logic                  head_done;

  function automatic logic [PtrWidth-1:0] ptr_inc(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(FifoDepth - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  // every fifo entry has a matching outstanding read
  assign fifo_empty = (out_cnt == '0);
  assign head_done  = ~fifo_empty & (valid_cnt == fifo_mem[rd_ptr]);

  always_ff @(posedge AvlClk_i)
  begin
    if (rd_accept_i)
      fifo_mem[wr_ptr] <= burst_count_i;
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (rd_accept_i)
        wr_ptr <= ptr_inc(wr_ptr);
      if (head_done)
        rd_ptr <= ptr_inc(rd_ptr);
    end
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      valid_cnt <= '0;
    else if (head_done)
      valid_cnt <= BurstWidth'(TxsReadDataValid_i);  // a word in this cycle belongs to the next read
    else if (TxsReadDataValid_i)
      valid_cnt <= valid_cnt + 1'b1;
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      out_cnt <= '0;
    else if (rd_accept_i & ~head_done)
      out_cnt <= out_cnt + 1'b1;
    else if (head_done & ~rd_accept_i)
      out_cnt <= out_cnt - 1'b1;
  end

  assign rd_slot_free_o = (out_cnt < CntWidth'(MaxPendingReads));

endmodule

//--- logic/rd_split_calc.sv
`timescale 1ns/100ps

module rd_split_calc #(
  parameter int AddrWidth = 32
) (
  input  logic                                    AvlClk_i,
  input  logic                                    Rstn_i,
  input  logic                                    rd_load_i,
  input  logic                                    rd_hdr_sent_i,
  input  logic [avl_cfg_pkg::BurstWidth-1:0]      burst_count_i,
  input  logic [AddrWidth-1:0]                    start_addr_i,
  input  logic [avl_cfg_pkg::MaxRdSizeWidth-1:0]  max_rd_code_i,
  output logic [avl_cfg_pkg::RdBytesWidth-1:0]    seg_bytes_o,
  output logic [AddrWidth-1:0]                    seg_addr_o,
  output logic                                    seg_last_o
);

  localparam int RdBytesWidth = avl_cfg_pkg::RdBytesWidth;
  localparam int WordBits     = $clog2(avl_cfg_pkg::WordBytes);
  localparam int BndBits      = $clog2(tlp_hdr_pkg::BoundaryBytes);
  localparam int BndWidth     = BndBits + 1;  // holds a full 4 KB

  logic [RdBytesWidth-1:0] remain_q;
  logic [AddrWidth-1:0]    next_addr;
  logic [RdBytesWidth-1:0] next_remain;
  logic [RdBytesWidth-1:0] max_rd_size;
  logic [BndWidth-1:0]     to_bnd;
  logic                    remain_fits;
  logic                    bnd_limits;
  logic [RdBytesWidth-1:0] next_seg_bytes;
  logic                    seg_update;

  // max read request size decode
  always_comb
  begin
    if (max_rd_code_i == '0)
      max_rd_size = RdBytesWidth'(avl_cfg_pkg::RdSize128);
    else if (max_rd_code_i == avl_cfg_pkg::MaxRdSizeWidth'(1))
      max_rd_size = RdBytesWidth'(avl_cfg_pkg::RdSize256);
    else
      max_rd_size = RdBytesWidth'(avl_cfg_pkg::RdSize512);
  end

  assign seg_update = rd_load_i | rd_hdr_sent_i;

  // start of the next segment from a fresh read or the rest of the current one
  always_comb
  begin
    if (rd_load_i)
    begin
      next_addr   = {start_addr_i[AddrWidth-1:WordBits], {WordBits{1'b0}}};
      next_remain = RdBytesWidth'(burst_count_i) * RdBytesWidth'(avl_cfg_pkg::WordBytes);
    end
    else
    begin
      next_addr   = seg_addr_o + AddrWidth'(seg_bytes_o);
      next_remain = remain_q - seg_bytes_o;
    end
  end

  assign to_bnd = BndWidth'(tlp_hdr_pkg::BoundaryBytes) - BndWidth'(next_addr[BndBits-1:0]);

  assign remain_fits = (next_remain <= max_rd_size) & (BndWidth'(next_remain) <= to_bnd);
  assign bnd_limits  = (to_bnd <= BndWidth'(max_rd_size));  // boundary is the tighter limit

  always_comb
  begin
    if (remain_fits)
      next_seg_bytes = next_remain;
    else if (bnd_limits)
      next_seg_bytes = RdBytesWidth'(to_bnd);
    else
      next_seg_bytes = max_rd_size;
  end

  always_ff @(posedge AvlClk_i)
  begin
    if (seg_update)
    begin
      seg_addr_o  <= next_addr;
      remain_q    <= next_remain;
      seg_bytes_o <= next_seg_bytes;
    end
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      seg_last_o <= 1'b0;
    else if (seg_update)
      seg_last_o <= remain_fits;  // whole rest goes out in this segment
  end

endmodule

//--- logic/tlp_hdr_pkg.sv
package tlp_hdr_pkg;

  // request header as written into the command fifo
  parameter int HdrWidth = 99;

  parameter int PcieAddrWidth = 64;
  parameter int AddrLsb       = 0;      // address in bits 63:0

  // request type flags
  parameter int IsRd32Bit = 64;
  parameter int IsRd64Bit = 65;
  parameter int IsWr32Bit = 66;
  parameter int IsWr64Bit = 67;

  parameter int BeWidth      = 4;
  parameter int FbeLsb       = 70;      // first dw byte enables
  parameter int TagLsb       = 74;
  parameter int MsiBit       = 81;
  parameter int LenLsb       = 85;      // length in dw
  parameter int LbeLsb       = 94;      // last dw byte enables
  parameter int LastSubRdBit = 98;      // final segment of a split read

  parameter int TagWidth = 4;
  parameter int LenWidth = 9;

  // pcie rules
  parameter int BoundaryBytes = 4096;   // a request never crosses this
  parameter int DwBytes       = 4;

endpackage

//--- logic/tlp_tx_read_ctrl.sv
`timescale 1ns/100ps

module tlp_tx_read_ctrl #(
  parameter int AddrWidth       = 32,
  parameter int IrqNum          = 1,
  parameter int MaxPendingReads = 8,
  parameter int FifoDepth       = 16
) (
  input  logic                                      AvlClk_i,
  input  logic                                      Rstn_i,
  // avalon read port
  input  logic                                      TxChipSelect_i,
  input  logic                                      TxRead_i,
  input  logic [avl_cfg_pkg::BurstWidth-1:0]        TxBurstCount_i,
  input  logic [AddrWidth-1:0]                      TxAddress_i,   // byte address
  output logic                                      TxWaitRequest_o,
  // command fifo
  input  logic [avl_cfg_pkg::CmdFifoUsedWidth-1:0]  CmdFifoUsedW_i,
  output logic                                      TxReqWr_o,
  output logic [tlp_hdr_pkg::HdrWidth-1:0]          TxReqHeader_o,
  output logic                                      CmdFifoBusy_o,
  input  logic                                      TxsReadDataValid_i,
  // configuration
  input  logic [31:0]                               DevCsr_i,
  input  logic                                      MasterEnable_i,
  input  logic [15:0]                               MsiCsr_i,
  input  logic [tlp_hdr_pkg::PcieAddrWidth-1:0]     MsiAddr_i,
  input  logic [avl_cfg_pkg::IrqEnaWidth-1:0]       PCIeIrqEna_i,
  // interrupt sources
  input  logic [IrqNum-1:0]                         RxmIrq_i,
  input  logic                                      A2PMbWrReq_i,
  input  logic [avl_cfg_pkg::MbAddrBits-1:0]        A2PMbWrAddr_i
);

  logic                                 rd_accept;
  logic                                 rd_load;
  logic                                 rd_hdr_sent;
  logic                                 msi_sent;
  logic                                 rd_slot_free;
  logic                                 msi_pending;
  logic [avl_cfg_pkg::RdBytesWidth-1:0] seg_bytes;
  logic [AddrWidth-1:0]                 seg_addr;
  logic                                 seg_last;

  txs_req_ctrl #(
    .AddrWidth (AddrWidth)
  ) txs_req_ctrl_i (
    .AvlClk_i        (AvlClk_i),
    .Rstn_i          (Rstn_i),
    .TxChipSelect_i  (TxChipSelect_i),
    .TxRead_i        (TxRead_i),
    .CmdFifoUsedW_i  (CmdFifoUsedW_i),
    .MasterEnable_i  (MasterEnable_i),
    .MsiAddr_i       (MsiAddr_i),
    .rd_slot_free_i  (rd_slot_free),
    .msi_pending_i   (msi_pending),
    .seg_bytes_i     (seg_bytes),
    .seg_addr_i      (seg_addr),
    .seg_last_i      (seg_last),
    .TxWaitRequest_o (TxWaitRequest_o),
    .TxReqWr_o       (TxReqWr_o),
    .TxReqHeader_o   (TxReqHeader_o),
    .CmdFifoBusy_o   (CmdFifoBusy_o),
    .rd_accept_o     (rd_accept),
    .rd_load_o       (rd_load),
    .rd_hdr_sent_o   (rd_hdr_sent),
    .msi_sent_o      (msi_sent)
  );

  rd_split_calc #(
    .AddrWidth (AddrWidth)
  ) rd_split_calc_i (
    .AvlClk_i      (AvlClk_i),
    .Rstn_i        (Rstn_i),
    .rd_load_i     (rd_load),
    .rd_hdr_sent_i (rd_hdr_sent),
    .burst_count_i (TxBurstCount_i),
    .start_addr_i  (TxAddress_i),
    .max_rd_code_i (DevCsr_i[avl_cfg_pkg::MaxRdSizeLsb +: avl_cfg_pkg::MaxRdSizeWidth]),
    .seg_bytes_o   (seg_bytes),
    .seg_addr_o    (seg_addr),
    .seg_last_o    (seg_last)
  );

  pending_rd_tracker #(
    .MaxPendingReads (MaxPendingReads),
    .FifoDepth       (FifoDepth)
  ) pending_rd_tracker_i (
    .AvlClk_i           (AvlClk_i),
    .Rstn_i             (Rstn_i),
    .rd_accept_i        (rd_accept),
    .burst_count_i      (TxBurstCount_i),
    .TxsReadDataValid_i (TxsReadDataValid_i),
    .rd_slot_free_o     (rd_slot_free)
  );

  msi_request #(
    .IrqNum (IrqNum)
  ) msi_request_i (
    .AvlClk_i      (AvlClk_i),
    .Rstn_i        (Rstn_i),
    .RxmIrq_i      (RxmIrq_i),
    .PCIeIrqEna_i  (PCIeIrqEna_i),
    .A2PMbWrReq_i  (A2PMbWrReq_i),
    .A2PMbWrAddr_i (A2PMbWrAddr_i),
    .msi_en_i      (MsiCsr_i[0]),   // msi enable bit
    .msi_sent_i    (msi_sent),
    .msi_pending_o (msi_pending)
  );

endmodule

//--- logic/txs_req_ctrl.sv
`timescale 1ns/100ps

module txs_req_ctrl #(
  parameter int AddrWidth = 32
) (
  input  logic                                      AvlClk_i,
  input  logic                                      Rstn_i,
  input  logic                                      TxChipSelect_i,
  input  logic                                      TxRead_i,
  input  logic [avl_cfg_pkg::CmdFifoUsedWidth-1:0]  CmdFifoUsedW_i,
  input  logic                                      MasterEnable_i,
  input  logic [tlp_hdr_pkg::PcieAddrWidth-1:0]     MsiAddr_i,
  input  logic                                      rd_slot_free_i,
  input  logic                                      msi_pending_i,
  input  logic [avl_cfg_pkg::RdBytesWidth-1:0]      seg_bytes_i,
  input  logic [AddrWidth-1:0]                      seg_addr_i,
  input  logic                                      seg_last_i,
  output logic                                      TxWaitRequest_o,
  output logic                                      TxReqWr_o,
  output logic [tlp_hdr_pkg::HdrWidth-1:0]          TxReqHeader_o,
  output logic                                      CmdFifoBusy_o,
  output logic                                      rd_accept_o,
  output logic                                      rd_load_o,
  output logic                                      rd_hdr_sent_o,
  output logic                                      msi_sent_o
);

  localparam int UsedWidth  = avl_cfg_pkg::CmdFifoUsedWidth;
  localparam int PAddrWidth = tlp_hdr_pkg::PcieAddrWidth;
  localparam int HalfAddr   = PAddrWidth / 2;
  localparam int LenWidth   = tlp_hdr_pkg::LenWidth;
  localparam int BeWidth    = tlp_hdr_pkg::BeWidth;
  localparam int TagWidth   = tlp_hdr_pkg::TagWidth;

  typedef enum logic [2:0] {
    StIdle,
    StWait,     // waiting for room in the command fifo
    StRdHdr,
    StRdPipe,   // lets the split calculator catch up
    StMsi
  } state_e;

  state_e                state_q;
  state_e                state_d;
  logic                  cmd_fifo_ok;
  logic [TagWidth-1:0]   tag_q;
  logic [PAddrWidth-1:0] rd_addr64;
  logic                  rd_addr_32;
  logic                  msi_addr_32;

  assign cmd_fifo_ok = (CmdFifoUsedW_i <= UsedWidth'(avl_cfg_pkg::CmdFifoOkMax));

  // a pending msi blocks new reads
  assign rd_accept_o = (state_q == StIdle) & TxChipSelect_i & TxRead_i & rd_slot_free_i &
                       ~msi_pending_i & MasterEnable_i;
  assign rd_load_o   = rd_accept_o;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      StIdle:
        if (msi_pending_i & cmd_fifo_ok & MasterEnable_i)
          state_d = StMsi;
        else if (rd_accept_o)
          state_d = StWait;
      StWait:
        if (cmd_fifo_ok)
          state_d = StRdHdr;
      StRdHdr:
        state_d = seg_last_i ? StIdle : StRdPipe;
      StRdPipe:
        state_d = StWait;
      StMsi:
        state_d = StIdle;
      default:
        state_d = StIdle;
    endcase
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      state_q <= StIdle;
    else
      state_q <= state_d;
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      tag_q <= '0;
    else if (rd_hdr_sent_o)
      tag_q <= tag_q + 1'b1;  // wraps around
  end

  assign TxWaitRequest_o = ~rd_accept_o;
  assign rd_hdr_sent_o   = (state_q == StRdHdr);
  assign msi_sent_o      = (state_q == StMsi);
  assign TxReqWr_o       = rd_hdr_sent_o | msi_sent_o;
  assign CmdFifoBusy_o   = (state_q == StWait) | msi_pending_i;

  assign rd_addr64   = PAddrWidth'(seg_addr_i);
  assign rd_addr_32  = (rd_addr64[PAddrWidth-1:HalfAddr] == '0);
  assign msi_addr_32 = (MsiAddr_i[PAddrWidth-1:HalfAddr] == '0);

  // header fields
  always_comb
  begin
    TxReqHeader_o = '0;
    if (msi_sent_o)
    begin
      TxReqHeader_o[tlp_hdr_pkg::AddrLsb +: PAddrWidth] = MsiAddr_i;
      TxReqHeader_o[tlp_hdr_pkg::IsWr32Bit]             = msi_addr_32;
      TxReqHeader_o[tlp_hdr_pkg::IsWr64Bit]             = ~msi_addr_32;
      TxReqHeader_o[tlp_hdr_pkg::FbeLsb +: BeWidth]     = '1;
      TxReqHeader_o[tlp_hdr_pkg::LenLsb +: LenWidth]    = LenWidth'(1);  // single dw write
      TxReqHeader_o[tlp_hdr_pkg::MsiBit]                = 1'b1;
    end
    else
    begin
      TxReqHeader_o[tlp_hdr_pkg::AddrLsb +: PAddrWidth] = rd_addr64;
      TxReqHeader_o[tlp_hdr_pkg::IsRd32Bit]             = rd_addr_32;
      TxReqHeader_o[tlp_hdr_pkg::IsRd64Bit]             = ~rd_addr_32;
      TxReqHeader_o[tlp_hdr_pkg::FbeLsb +: BeWidth]     = '1;
      TxReqHeader_o[tlp_hdr_pkg::TagLsb +: TagWidth]    = tag_q;
      TxReqHeader_o[tlp_hdr_pkg::LenLsb +: LenWidth]    =
        LenWidth'(seg_bytes_i / tlp_hdr_pkg::DwBytes);
      TxReqHeader_o[tlp_hdr_pkg::LbeLsb +: BeWidth]     = '1;  // reads are whole words
      TxReqHeader_o[tlp_hdr_pkg::LastSubRdBit]          = seg_last_i;
    end
  end

endmodule
